/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_trap_unit
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Test passed'

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
riscv_csr_pkg.sv
trap_ctrl_pkg.sv
csr_mregs.sv
machine_timer.sv
clint.sv
trap_unit_top.sv
tb_clk_gen.sv
tb_trap_unit.sv

/* clint.sv */
// trap sequencer with entry decision, mepc/mstatus/mcause write sequence, stall and redirect pulse
`timescale 1ns/1ps
`default_nettype none

module clint import riscv_csr_pkg::*, trap_ctrl_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,

    // from execute
    input  wire inst_addr_t inst_addr_i,
    input  wire             jump_flag_i,
    input  wire inst_addr_t jump_addr_i,
    input  wire             atom_busy_i,   // atomic op in flight
    input  wire             ecall_i,
    input  wire             ebreak_i,
    input  wire             mret_i,

    // from timer
    input  wire             timer_irq_i,

    // from csr file
    input  wire xlen_t      mtvec_i,
    input  wire xlen_t      mepc_i,
    input  wire xlen_t      mstatus_i,

    // to pipeline control
    output logic            stall_o,

    // trap write port into the csr file
    output logic            trap_we_o,
    output csr_addr_t       trap_waddr_o,
    output xlen_t           trap_wdata_o,

    // redirect to fetch
    output logic            int_assert_o,
    output inst_addr_t      int_addr_o
);

    int_state_e int_state;
    csr_state_e csr_state;

    logic       seq_busy;
    logic       sync_req;
    logic       trap_take;
    inst_addr_t epc;           // address saved at acceptance
    xlen_t      cause;         // cause latched at acceptance
    xlen_t      trap_mstatus;
    xlen_t      mret_mstatus;

    // the mcause write still lands the cycle after the fsm returns to idle
    assign seq_busy  = (csr_state != CSR_IDLE) | trap_we_o;
    assign sync_req  = (ecall_i | ebreak_i) & ~atom_busy_i;
    assign trap_take = (int_state == INT_SYNC_ASSERT) | (int_state == INT_ASYNC_ASSERT);

    // entry decision in priority order sync, mret, timer
    always_comb begin
        int_state = INT_IDLE;
        if (!seq_busy) begin
            if (sync_req) begin
                int_state = INT_SYNC_ASSERT;
            end else if (mret_i) begin
                int_state = INT_MRET;
            end else if (timer_irq_i && mstatus_i[MSTATUS_MIE]) begin
                int_state = INT_ASYNC_ASSERT;
            end
        end
    end

    assign stall_o = (int_state != INT_IDLE) | seq_busy;  // acceptance cycle included

    // csr write sequence
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_state <= CSR_IDLE;
        end else begin
            case (csr_state)
                CSR_IDLE: begin
                    if (trap_take) begin
                        csr_state <= trap_ctrl_pkg::CSR_MEPC;
                    end else if (int_state == INT_MRET) begin
                        csr_state <= CSR_MSTATUS_MRET;
                    end
                end
                trap_ctrl_pkg::CSR_MEPC:    csr_state <= trap_ctrl_pkg::CSR_MSTATUS;
                trap_ctrl_pkg::CSR_MSTATUS: csr_state <= trap_ctrl_pkg::CSR_MCAUSE;
                trap_ctrl_pkg::CSR_MCAUSE:  csr_state <= CSR_IDLE;
                CSR_MSTATUS_MRET:           csr_state <= CSR_IDLE;
                default:                    csr_state <= CSR_IDLE;
            endcase
        end
    end

    // capture cause and return address on trap entry
    always_ff @(posedge clk) begin
        if (trap_take) begin
            epc <= jump_flag_i ? (jump_addr_i - INST_STEP) : inst_addr_i;  // jump target minus one step
            if (int_state == INT_ASYNC_ASSERT) begin
                cause <= CAUSE_M_TIMER_IRQ;
            end else if (ecall_i) begin
                cause <= CAUSE_ECALL_M;
            end else begin
                cause <= CAUSE_BREAKPOINT;
            end
        end
    end

    // mstatus images built from the value still in the csr file
    always_comb begin
        trap_mstatus               = mstatus_i;
        trap_mstatus[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];  // stash mie
        trap_mstatus[MSTATUS_MIE]  = 1'b0;
        mret_mstatus               = mstatus_i;
        mret_mstatus[MSTATUS_MIE]  = mstatus_i[MSTATUS_MPIE]; // restore mie
        mret_mstatus[MSTATUS_MPIE] = 1'b1;
    end

    // write enable and redirect pulse trail the state by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_we_o    <= 1'b0;
            int_assert_o <= 1'b0;
        end else begin
            trap_we_o    <= (csr_state != CSR_IDLE);
            int_assert_o <= (csr_state == trap_ctrl_pkg::CSR_MCAUSE) |
                            (csr_state == CSR_MSTATUS_MRET);
        end
    end

    always_ff @(posedge clk) begin
        case (csr_state)
            trap_ctrl_pkg::CSR_MEPC: begin
                trap_waddr_o <= riscv_csr_pkg::CSR_MEPC;
                trap_wdata_o <= xlen_t'(epc);
            end
            trap_ctrl_pkg::CSR_MSTATUS: begin
                trap_waddr_o <= riscv_csr_pkg::CSR_MSTATUS;
                trap_wdata_o <= trap_mstatus;
            end
            trap_ctrl_pkg::CSR_MCAUSE: begin
                trap_waddr_o <= riscv_csr_pkg::CSR_MCAUSE;
                trap_wdata_o <= cause;
                int_addr_o   <= inst_addr_t'(mtvec_i);  // direct mode handler
            end
            CSR_MSTATUS_MRET: begin
                trap_waddr_o <= riscv_csr_pkg::CSR_MSTATUS;
                trap_wdata_o <= mret_mstatus;
                int_addr_o   <= inst_addr_t'(mepc_i);   // back to the trapped instruction
            end
            default: ;  // hold payload
        endcase
    end

    a_int_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        int_assert_o |=> !int_assert_o);

    // last csr write of a sequence goes out together with the redirect pulse
    a_trap_we_ends_with_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(trap_we_o) |-> $past(int_assert_o));

endmodule : clint

`default_nettype wire

/* csr_mregs.sv */
// machine trap csr file: mtvec, mepc, mstatus, mcause with software and trap write ports
`timescale 1ns/1ps
`default_nettype none

module csr_mregs import riscv_csr_pkg::*; (
    input  wire         clk,
    input  wire         rst_n,

    // software write from execute
    input  wire         csr_we_i,
    input  wire csr_addr_t csr_waddr_i,
    input  wire xlen_t  csr_wdata_i,

    // trap write from the sequencer
    input  wire         trap_we_i,
    input  wire csr_addr_t trap_waddr_i,
    input  wire xlen_t  trap_wdata_i,

    // combinational read
    input  wire csr_addr_t csr_raddr_i,
    output xlen_t       csr_rdata_o,

    // direct taps for the sequencer
    output xlen_t       mtvec_o,
    output xlen_t       mepc_o,
    output xlen_t       mstatus_o
);

    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mstatus;
    xlen_t     mcause;

    logic      we;
    csr_addr_t waddr;
    xlen_t     wdata;

    // trap port has priority
    assign we    = trap_we_i | csr_we_i;
    assign waddr = trap_we_i ? trap_waddr_i : csr_waddr_i;
    assign wdata = trap_we_i ? trap_wdata_i : csr_wdata_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec   <= '0;
            mepc    <= '0;
            mstatus <= '0;
            mcause  <= '0;
        end else if (we) begin
            case (waddr)
                CSR_MTVEC:   mtvec   <= {wdata[XLEN-1:MTVEC_ALIGN], {MTVEC_ALIGN{1'b0}}};
                CSR_MEPC:    mepc    <= wdata;
                CSR_MSTATUS: mstatus <= wdata;
                CSR_MCAUSE:  mcause  <= wdata;
                default: ;  // unknown address, write dropped
            endcase
        end
    end

    always_comb begin
        case (csr_raddr_i)
            CSR_MTVEC:   csr_rdata_o = mtvec;
            CSR_MEPC:    csr_rdata_o = mepc;
            CSR_MSTATUS: csr_rdata_o = mstatus;
            CSR_MCAUSE:  csr_rdata_o = mcause;
            default:     csr_rdata_o = '0;
        endcase
    end

    assign mtvec_o   = mtvec;
    assign mepc_o    = mepc;
    assign mstatus_o = mstatus;

    // execute must hold off software writes while the trap sequencer runs
    a_no_write_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(trap_we_i && csr_we_i));

endmodule : csr_mregs

`default_nettype wire

/* machine_timer.sv */
// machine timer: free-running mtime, writable mtimecmp, registered timer interrupt level
`timescale 1ns/1ps
`default_nettype none

module machine_timer import riscv_csr_pkg::*, trap_ctrl_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,

    // mtimecmp write, one half per access
    input  wire        timer_we_i,
    input  wire        timer_hi_i,     // 1 = upper word
    input  wire xlen_t timer_wdata_i,

    output logic       timer_irq_o     // level, mtime >= mtimecmp
);

    mtime_t mtime;
    mtime_t mtimecmp;

    // one tick per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + mtime_t'(1);
        end
    end

    // all ones out of reset, no interrupt until software programs it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else if (timer_we_i) begin
            if (timer_hi_i) begin
                mtimecmp[MTIME_W-1:XLEN] <= timer_wdata_i;
            end else begin
                mtimecmp[XLEN-1:0] <= timer_wdata_i;
            end
        end
    end

    // registered compare keeps the 64-bit comparator off the trap path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    // counter is monotonic, 64 bits never wrap in practice
    a_mtime_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        mtime >= $past(mtime));

endmodule : machine_timer

`default_nettype wire

/* riscv_csr_pkg.sv */
// architectural csr description: word and address types, csr addresses, mstatus bits, cause codes
`default_nettype none

package riscv_csr_pkg;

    // basic widths
    localparam int XLEN       = 32;  // rv32 register word
    localparam int CSR_ADDR_W = 12;  // csr address space

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

    // machine trap csr addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // mtvec base alignment, direct mode only
    // the mode field is hardwired to zero
    localparam int MTVEC_ALIGN = 2;

    // mstatus bit positions
    localparam int MSTATUS_MIE  = 3;  // global machine interrupt enable
    localparam int MSTATUS_MPIE = 7;  // mie saved on trap entry

    // mcause values
    // bit 31 marks an interrupt, the rest is the exception code
    localparam xlen_t CAUSE_ECALL_M     = 32'd11;         // environment call from m-mode
    localparam xlen_t CAUSE_BREAKPOINT  = 32'd3;          // ebreak
    localparam xlen_t CAUSE_M_TIMER_IRQ = 32'h8000_0007;  // machine timer interrupt

endpackage : riscv_csr_pkg

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock and reset source: 40 ns clock, active low reset held for 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_NS      = 20;  // 40 ns period
    localparam int RESET_CYCLES = 5;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_NS) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        rst_n_o = 1'b1;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* tb_trap_unit.sv */
// trap unit testbench: lcg stimulus, trap reference function, compare process, cycle watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_trap_unit import riscv_csr_pkg::*, trap_ctrl_pkg::*; ();

    localparam int N_ROUNDS    = 4;   // each round writes all four csrs
    localparam int N_TRAPS     = 24;  // ecall / ebreak mix
    localparam int N_MRET      = 8;
    localparam int N_ITEMS     = 4 * N_ROUNDS + N_TRAPS + N_MRET + 3;  // + reset, hold-off, timer
    localparam int CYCLE_LIMIT = 40 * N_ITEMS + 500;

    typedef enum logic [1:0] {KIND_ECALL, KIND_EBREAK, KIND_TIMER, KIND_MRET} trap_kind_e;

    typedef struct packed {
        xlen_t      mepc;
        xlen_t      mstatus;
        xlen_t      mcause;
        inst_addr_t target;   // expected int_addr_o
    } trap_result_t;

    logic         clk;
    logic         rst_n;
    inst_addr_t   inst_addr, jump_addr, int_addr;
    logic         jump_flag, atom_busy, ecall, ebreak, mret;
    logic         csr_we, timer_we, timer_hi, stall, int_assert;
    csr_addr_t    csr_waddr, csr_raddr;
    xlen_t        csr_wdata, timer_wdata, csr_rdata;

    csr_addr_t    stim_raddr;     // read address from stimulus
    csr_addr_t    chk_raddr;      // read address from the compare process
    logic         chk_busy;       // compare process owns the read port
    logic [31:0]  lcg_state;
    trap_result_t exp_q [$];      // pushed by stimulus, walked by checks_done
    int           checks_done;
    int           cycle_count;
    xlen_t        m_mtvec, m_mepc, m_mstatus, m_mcause;  // expected csr contents

    assign csr_raddr = chk_busy ? chk_raddr : stim_raddr;

    tb_clk_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    trap_unit_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_addr_i   (inst_addr),
        .jump_flag_i   (jump_flag),
        .jump_addr_i   (jump_addr),
        .atom_busy_i   (atom_busy),
        .ecall_i       (ecall),
        .ebreak_i      (ebreak),
        .mret_i        (mret),
        .csr_we_i      (csr_we),
        .csr_waddr_i   (csr_waddr),
        .csr_wdata_i   (csr_wdata),
        .csr_raddr_i   (csr_raddr),
        .timer_we_i    (timer_we),
        .timer_hi_i    (timer_hi),
        .timer_wdata_i (timer_wdata),
        .csr_rdata_o   (csr_rdata),
        .stall_o       (stall),
        .int_assert_o  (int_assert),
        .int_addr_o    (int_addr)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // numerical recipes lcg
        return lcg_state;
    endfunction

    // expected csrs and redirect after a trap or mret, from the current csr model
    function automatic trap_result_t ref_trap(input xlen_t old_mstatus, input trap_kind_e kind,
                                              input inst_addr_t pc, input logic jumped,
                                              input inst_addr_t jump_target);
        trap_result_t r;
        r.mstatus = old_mstatus;
        if (kind == KIND_MRET) begin
            r.mepc                  = m_mepc;      // untouched
            r.mcause                = m_mcause;
            r.mstatus[MSTATUS_MIE]  = old_mstatus[MSTATUS_MPIE];
            r.mstatus[MSTATUS_MPIE] = 1'b1;
            r.target                = m_mepc;
        end else begin
            r.mepc                  = jumped ? jump_target - INST_STEP : pc;
            r.mstatus[MSTATUS_MPIE] = old_mstatus[MSTATUS_MIE];
            r.mstatus[MSTATUS_MIE]  = 1'b0;
            r.mcause = (kind == KIND_ECALL)  ? CAUSE_ECALL_M :
                       (kind == KIND_EBREAK) ? CAUSE_BREAKPOINT : CAUSE_M_TIMER_IRQ;
            r.target                = m_mtvec;     // direct mode
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input string what, input inst_addr_t got, input inst_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at %0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input xlen_t data);
        @(negedge clk);
        csr_we    = 1'b1;
        csr_waddr = addr;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
        case (addr)
            riscv_csr_pkg::CSR_MTVEC:   m_mtvec   = data & ~xlen_t'(3);  // low bits read zero
            riscv_csr_pkg::CSR_MEPC:    m_mepc    = data;
            riscv_csr_pkg::CSR_MSTATUS: m_mstatus = data;
            riscv_csr_pkg::CSR_MCAUSE:  m_mcause  = data;
            default: ;
        endcase
    endtask

    task automatic write_mtimecmp(input logic hi, input xlen_t data);
        @(negedge clk);
        timer_we    = 1'b1;
        timer_hi    = hi;
        timer_wdata = data;
        @(negedge clk);
        timer_we = 1'b0;
    endtask

    // stimulus side read, one cycle for the address to settle
    task automatic expect_csr(input string what, input csr_addr_t addr, input xlen_t exp);
        @(negedge clk);
        stim_raddr = addr;
        @(negedge clk);
        check_word(what, csr_rdata, exp);
    endtask

    // compare process read, already on a falling edge
    task automatic check_csr(input string what, input csr_addr_t addr, input xlen_t exp);
        chk_raddr = addr;
        @(negedge clk);
        check_word(what, csr_rdata, exp);
    endtask

    task automatic round_trip(input string what, input csr_addr_t addr, input xlen_t keep);
        xlen_t data;
        data = next_rand();
        write_csr(addr, data);
        expect_csr(what, addr, data & keep);
    endtask

    // wait for the compare process, then take over the new csr state
    task automatic finish_trap(input trap_result_t exp);
        while (checks_done < exp_q.size()) @(negedge clk);
        m_mepc    = exp.mepc;
        m_mstatus = exp.mstatus;
        m_mcause  = exp.mcause;
    endtask

    task automatic run_trap(input trap_kind_e kind);
        inst_addr_t   pc;
        inst_addr_t   target;
        logic [31:0]  r;
        trap_result_t exp;
        pc     = next_rand() & 32'hffff_fffc;
        target = next_rand() & 32'hffff_fffc;
        r      = next_rand();
        exp    = ref_trap(m_mstatus, kind, pc, r[9], target);
        exp_q.push_back(exp);
        @(negedge clk);
        inst_addr = pc;
        jump_flag = r[9];
        jump_addr = target;
        ecall     = (kind == KIND_ECALL);
        ebreak    = (kind == KIND_EBREAK);
        mret      = (kind == KIND_MRET);
        @(negedge clk);  // single cycle request
        {ecall, ebreak, mret} = '0;
        finish_trap(exp);
    endtask

    initial begin : compare
        trap_result_t exp;
        chk_busy    = 1'b0;
        chk_raddr   = '0;
        checks_done = 0;
        forever begin
            @(negedge clk);
            if (int_assert === 1'b1) begin
                if (checks_done >= exp_q.size()) begin
                    abort_run("int_assert_o pulsed while no trap or mret was pending");
                end else begin
                    exp = exp_q[checks_done];
                    if (stall !== 1'b1) begin
                        abort_run($sformatf("error at %0t: stall_o low at redirect", $time));
                    end
                    check_addr("int_addr_o", int_addr, exp.target);
                    @(negedge clk);  // last csr write lands on the edge in between
                    chk_busy = 1'b1;
                    check_csr("mepc", riscv_csr_pkg::CSR_MEPC, exp.mepc);
                    check_csr("mstatus", riscv_csr_pkg::CSR_MSTATUS, exp.mstatus);
                    check_csr("mcause", riscv_csr_pkg::CSR_MCAUSE, exp.mcause);
                    chk_busy    = 1'b0;
                    checks_done = checks_done + 1;
                end
            end
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        abort_run($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    initial begin : stimulus
        xlen_t        word;
        inst_addr_t   pc;
        trap_result_t exp;
        lcg_state = 32'h8081_3dbb;
        {jump_flag, atom_busy, ecall, ebreak, mret, csr_we, timer_we, timer_hi} = '0;
        {inst_addr, jump_addr, csr_wdata, timer_wdata} = '0;
        {csr_waddr, stim_raddr} = '0;
        {m_mtvec, m_mepc, m_mstatus, m_mcause} = '0;
        @(posedge rst_n);
        @(negedge clk);
        if (stall !== 1'b0 || int_assert !== 1'b0) begin
            abort_run("stall_o or int_assert_o active right after reset");
        end
        expect_csr("mtvec", riscv_csr_pkg::CSR_MTVEC, '0);
        expect_csr("mepc", riscv_csr_pkg::CSR_MEPC, '0);
        expect_csr("mstatus", riscv_csr_pkg::CSR_MSTATUS, '0);
        expect_csr("mcause", riscv_csr_pkg::CSR_MCAUSE, '0);
        repeat (50) @(negedge clk);  // any stray redirect trips the compare process

        for (int i = 0; i < N_ROUNDS; i++) begin
            round_trip("mtvec", riscv_csr_pkg::CSR_MTVEC, 32'hffff_fffc);
            round_trip("mepc", riscv_csr_pkg::CSR_MEPC, '1);
            round_trip("mstatus", riscv_csr_pkg::CSR_MSTATUS, '1);
            round_trip("mcause", riscv_csr_pkg::CSR_MCAUSE, '1);
        end

        // synchronous traps from random handler and status
        for (int i = 0; i < N_TRAPS; i++) begin
            write_csr(riscv_csr_pkg::CSR_MTVEC, next_rand());
            write_csr(riscv_csr_pkg::CSR_MSTATUS, next_rand());
            word = next_rand();
            if (word[5]) begin
                run_trap(KIND_EBREAK);
            end else begin
                run_trap(KIND_ECALL);
            end
        end

        // ecall parked behind an atomic op
        write_csr(riscv_csr_pkg::CSR_MTVEC, next_rand());
        pc = next_rand() & 32'hffff_fffc;
        @(negedge clk);
        inst_addr = pc;
        jump_flag = 1'b0;
        atom_busy = 1'b1;
        ecall     = 1'b1;
        repeat (20) @(negedge clk);
        if (stall !== 1'b0) begin
            abort_run($sformatf("error at %0t: stall_o high while atom_busy_i holds", $time));
        end
        exp = ref_trap(m_mstatus, KIND_ECALL, pc, 1'b0, '0);
        exp_q.push_back(exp);
        atom_busy = 1'b0;
        @(negedge clk);
        ecall = 1'b0;
        finish_trap(exp);

        for (int i = 0; i < N_MRET; i++) begin
            write_csr(riscv_csr_pkg::CSR_MEPC, next_rand() & 32'hffff_fffc);
            write_csr(riscv_csr_pkg::CSR_MSTATUS, next_rand());
            run_trap(KIND_MRET);
        end

        // timer pending with mie clear, then enable
        write_csr(riscv_csr_pkg::CSR_MTVEC, next_rand());
        word = next_rand();
        word[MSTATUS_MIE] = 1'b0;
        write_csr(riscv_csr_pkg::CSR_MSTATUS, word);
        write_mtimecmp(1'b1, '0);
        write_mtimecmp(1'b0, '0);  // mtime now past mtimecmp
        repeat (100) @(negedge clk);
        pc        = next_rand() & 32'hffff_fffc;
        inst_addr = pc;
        jump_flag = 1'b0;
        word[MSTATUS_MIE] = 1'b1;
        exp = ref_trap(word, KIND_TIMER, pc, 1'b0, '0);
        exp_q.push_back(exp);
        write_csr(riscv_csr_pkg::CSR_MSTATUS, word);
        finish_trap(exp);
        repeat (50) @(negedge clk);  // mie now clear, a second trap would be caught

        if (checks_done != exp_q.size()) begin
            abort_run("a trap was started but its redirect never came");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule : tb_trap_unit

`default_nettype wire

/* trap_ctrl_pkg.sv */
// trap control description: instruction address and timer types, sequencer state enums
`default_nettype none

package trap_ctrl_pkg;

    localparam int INST_ADDR_W = 32;  // fetch address width
    localparam int MTIME_W     = 64;  // mtime / mtimecmp width

    typedef logic [INST_ADDR_W-1:0] inst_addr_t;
    typedef logic [MTIME_W-1:0]     mtime_t;

    localparam inst_addr_t INST_STEP = 32'd4;  // bytes per instruction, no compressed

    // interrupt decision, one-hot
    typedef enum logic [3:0] {
        INT_IDLE         = 4'b0001,
        INT_SYNC_ASSERT  = 4'b0010,  // ecall / ebreak
        INT_ASYNC_ASSERT = 4'b0100,  // timer
        INT_MRET         = 4'b1000
    } int_state_e;

    // csr write sequence, one-hot
    typedef enum logic [4:0] {
        CSR_IDLE         = 5'b00001,
        CSR_MEPC         = 5'b00010,
        CSR_MSTATUS      = 5'b00100,
        CSR_MCAUSE       = 5'b01000,
        CSR_MSTATUS_MRET = 5'b10000
    } csr_state_e;

endpackage : trap_ctrl_pkg

`default_nettype wire

/* trap_unit_top.sv */
// trap unit top: machine timer, machine csr file and trap sequencer
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top import riscv_csr_pkg::*, trap_ctrl_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,

    // execute stage
    input  wire inst_addr_t inst_addr_i,
    input  wire             jump_flag_i,
    input  wire inst_addr_t jump_addr_i,
    input  wire             atom_busy_i,
    input  wire             ecall_i,
    input  wire             ebreak_i,
    input  wire             mret_i,

    // software csr access
    input  wire             csr_we_i,
    input  wire csr_addr_t  csr_waddr_i,
    input  wire xlen_t      csr_wdata_i,
    input  wire csr_addr_t  csr_raddr_i,

    // mtimecmp write
    input  wire             timer_we_i,
    input  wire             timer_hi_i,
    input  wire xlen_t      timer_wdata_i,

    output xlen_t           csr_rdata_o,
    output logic            stall_o,
    output logic            int_assert_o,
    output inst_addr_t      int_addr_o
);

    logic      timer_irq;
    xlen_t     mtvec;
    xlen_t     mepc;
    xlen_t     mstatus;
    logic      trap_we;
    csr_addr_t trap_waddr;
    xlen_t     trap_wdata;

    machine_timer u_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_we_i    (timer_we_i),
        .timer_hi_i    (timer_hi_i),
        .timer_wdata_i (timer_wdata_i),
        .timer_irq_o   (timer_irq)
    );

    csr_mregs u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_we_i     (csr_we_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_wdata_i  (csr_wdata_i),
        .trap_we_i    (trap_we),
        .trap_waddr_i (trap_waddr),
        .trap_wdata_i (trap_wdata),
        .csr_raddr_i  (csr_raddr_i),
        .csr_rdata_o  (csr_rdata_o),
        .mtvec_o      (mtvec),
        .mepc_o       (mepc),
        .mstatus_o    (mstatus)
    );

    clint u_clint (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_addr_i  (inst_addr_i),
        .jump_flag_i  (jump_flag_i),
        .jump_addr_i  (jump_addr_i),
        .atom_busy_i  (atom_busy_i),
        .ecall_i      (ecall_i),
        .ebreak_i     (ebreak_i),
        .mret_i       (mret_i),
        .timer_irq_i  (timer_irq),
        .mtvec_i      (mtvec),
        .mepc_i       (mepc),
        .mstatus_i    (mstatus),
        .stall_o      (stall_o),
        .trap_we_o    (trap_we),
        .trap_waddr_o (trap_waddr),
        .trap_wdata_o (trap_wdata),
        .int_assert_o (int_assert_o),
        .int_addr_o   (int_addr_o)
    );

endmodule : trap_unit_top

`default_nettype wire
